// ==== Makefile ====
# Verilator build and run of the clock testbench, RTL lint, clean

TOP := clock_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f vlog.f

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module clock_top -f vlog.f

clean:
	rm -rf obj_dir

// ==== hw/alarm_keeper.sv ====
// alarm_keeper: alarm sec/min/hour fields, changed only by stepping
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module alarm_keeper (
	input  wire       [2:0] i_step,	// {hour, min, sec}
	input  wire             clk,
	input  wire             rst_n,
	output clock_pkg::hms_t o_alarm_time
);

	logic [`HMS_W-1:0] sec_val;
	logic [`HMS_W-1:0] min_val;
	logic [`HMS_W-1:0] hour_val;

	// no counting here, steps wrap inside each field
	hms_field #(.MAX(`HMS_SEC_MAX)) u_sec (
		.i_count (1'b0),
		.i_step  (i_step[0]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (sec_val),
		.o_carry ()
	);

	hms_field #(.MAX(`HMS_MIN_MAX)) u_min (
		.i_count (1'b0),
		.i_step  (i_step[1]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (min_val),
		.o_carry ()
	);

	hms_field #(.MAX(`HMS_HOUR_MAX)) u_hour (
		.i_count (1'b0),
		.i_step  (i_step[2]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (hour_val),
		.o_carry ()
	);

	assign o_alarm_time = {hour_val, min_val, sec_val};

endmodule

`default_nettype wire

// ==== hw/clock_face.sv ====
// shown-time select, alarm compare, decimal split, segment decode, digit scan
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module clock_face #(
	parameter int SCAN_DIV = `SCAN_DIV_DEF
) (
	input  wire  clock_pkg::hms_t   i_time,
	input  wire  clock_pkg::hms_t   i_alarm_time,
	input  wire  clock_pkg::mode_e  i_mode,
	input  wire  clock_pkg::field_e i_field,
	input  wire                     i_alarm_en,
	input  wire                     clk,
	input  wire                     rst_n,
	output display_pkg::seg_t       o_seg,
	output logic                    o_seg_dp,
	output logic [`DIGITS-1:0]      o_seg_enb,	// active low, bit 0 = sec ones
	output logic                    o_alarm
);

	localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);
	localparam logic [2:0] IDX_LAST = 3'(`DIGITS - 1);

	clock_pkg::hms_t     shown;
	display_pkg::digits_u digits;
	logic [SCAN_W-1:0]   scan_cnt;
	logic [2:0]          scan_idx;
	logic [2:0]          dp_idx;
	logic                dp_on;

	// segments a..g lit high with a in the msb
	function automatic display_pkg::seg_t seg_decode(input display_pkg::bcd_t d);
		case (d)
			4'd0:    seg_decode = 7'b111_1110;
			4'd1:    seg_decode = 7'b011_0000;
			4'd2:    seg_decode = 7'b110_1101;
			4'd3:    seg_decode = 7'b111_1001;
			4'd4:    seg_decode = 7'b011_0011;
			4'd5:    seg_decode = 7'b101_1011;
			4'd6:    seg_decode = 7'b101_1111;
			4'd7:    seg_decode = 7'b111_0000;
			4'd8:    seg_decode = 7'b111_1111;
			4'd9:    seg_decode = 7'b111_0011;
			default: seg_decode = 7'b000_0000;
		endcase
	endfunction

	// ----------------------------------------------------------
	// shown time and decimal split
	// ----------------------------------------------------------
	assign shown = (i_mode == clock_pkg::MODE_ALARM) ? i_alarm_time : i_time;

	always_comb begin
		digits.by_name.hour_tens = 4'(shown.hour / 10);
		digits.by_name.hour_ones = 4'(shown.hour % 10);
		digits.by_name.min_tens  = 4'(shown.min / 10);
		digits.by_name.min_ones  = 4'(shown.min % 10);
		digits.by_name.sec_tens  = 4'(shown.sec / 10);
		digits.by_name.sec_ones  = 4'(shown.sec % 10);
	end

	// dp on the ones digit of the field being edited
	assign dp_on  = (i_mode != clock_pkg::MODE_CLOCK);
	assign dp_idx = {i_field, 1'b0};	// sec 0, min 2, hour 4

	// ----------------------------------------------------------
	// digit scan
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			scan_idx <= '0;
		end else if (scan_cnt == SCAN_LAST) begin
			scan_cnt <= '0;
			scan_idx <= (scan_idx == IDX_LAST) ? 3'd0 : scan_idx + 3'd1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// segment code and enable leave on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= ~`DIGITS'(1);
		end else begin
			o_seg     <= seg_decode(digits.by_scan[scan_idx]);
			o_seg_dp  <= dp_on && (scan_idx == dp_idx);
			o_seg_enb <= ~(`DIGITS'(1) << scan_idx);
		end
	end

	// sticky alarm cleared only by enable low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (o_alarm | (i_time == i_alarm_time));
	end

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

// ==== hw/clock_macros.svh ====
// field limits, widths, digit count and default dividers for the clock
`ifndef CLOCK_MACROS_SVH
`define CLOCK_MACROS_SVH

// ----------------------------------------------------------
// time fields
// ----------------------------------------------------------
`define HMS_SEC_MAX	59
`define HMS_MIN_MAX	59
`define HMS_HOUR_MAX	23
`define HMS_W		6	// wide enough for 0..59

// ----------------------------------------------------------
// display
// ----------------------------------------------------------
`define SEG_W		7	// segments a..g
`define DIGITS		6	// hh:mm:ss

`define TICK_DIV_DEF	50000000	// 50 MHz clk to 1 Hz
`define SCAN_DIV_DEF	5000		// 10 kHz digit rate

`endif

// ==== hw/clock_pkg.sv ====
// clock types: mode, field select and hour/min/sec time value
`include "clock_macros.svh"
`default_nettype none

package clock_pkg;

	// operating mode, cycled by the mode button
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SET   = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	// selected field, cycled by the field button
	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	// one time of day, binary per field
	typedef struct packed {
		logic [`HMS_W-1:0] hour;
		logic [`HMS_W-1:0] min;
		logic [`HMS_W-1:0] sec;
	} hms_t;

endpackage

`default_nettype wire

// ==== hw/clock_top.sv ====
// clock_top: six-digit 24-hour clock, control, time and alarm keepers, display face
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module clock_top #(
	parameter int TICK_DIV = `TICK_DIV_DEF,
	parameter int SCAN_DIV = `SCAN_DIV_DEF
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                i_btn_mode,
	input  wire                i_btn_field,
	input  wire                i_btn_step,
	input  wire                i_btn_alarm,
	output display_pkg::seg_t  o_seg,
	output logic               o_seg_dp,
	output logic [`DIGITS-1:0] o_seg_enb,
	output logic               o_alarm
);

	clock_pkg::mode_e  mode;
	clock_pkg::field_e field;
	logic              alarm_en;
	logic [2:0]        time_step;
	logic [2:0]        alarm_step;
	clock_pkg::hms_t   cur_time;
	clock_pkg::hms_t   alarm_time;

	mode_ctrl u_mode_ctrl (
		.i_btn_mode   (i_btn_mode),
		.i_btn_field  (i_btn_field),
		.i_btn_step   (i_btn_step),
		.i_btn_alarm  (i_btn_alarm),
		.clk          (clk),
		.rst_n        (rst_n),
		.o_mode       (mode),
		.o_field      (field),
		.o_alarm_en   (alarm_en),
		.o_time_step  (time_step),
		.o_alarm_step (alarm_step)
	);

	// time and alarm run side by side
	time_keeper #(.TICK_DIV(TICK_DIV)) u_time_keeper (
		.i_mode (mode),
		.i_step (time_step),
		.clk    (clk),
		.rst_n  (rst_n),
		.o_time (cur_time)
	);

	alarm_keeper u_alarm_keeper (
		.i_step       (alarm_step),
		.clk          (clk),
		.rst_n        (rst_n),
		.o_alarm_time (alarm_time)
	);

	clock_face #(.SCAN_DIV(SCAN_DIV)) u_clock_face (
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.i_mode       (mode),
		.i_field      (field),
		.i_alarm_en   (alarm_en),
		.clk          (clk),
		.rst_n        (rst_n),
		.o_seg        (o_seg),
		.o_seg_dp     (o_seg_dp),
		.o_seg_enb    (o_seg_enb),
		.o_alarm      (o_alarm)
	);

endmodule

`default_nettype wire

// ==== hw/display_pkg.sv ====
// display types: decimal digit, segment code, six-digit word with two views
`include "clock_macros.svh"
`default_nettype none

package display_pkg;

	typedef logic [3:0] bcd_t;		// one decimal digit
	typedef logic [`SEG_W-1:0] seg_t;	// {a,b,c,d,e,f,g}

	// named view, msb digit first
	typedef struct packed {
		bcd_t hour_tens;
		bcd_t hour_ones;
		bcd_t min_tens;
		bcd_t min_ones;
		bcd_t sec_tens;
		bcd_t sec_ones;
	} digits_named_t;

	// same 24 bits, written by name and read by scan position
	// scan position 0 is the seconds ones digit
	typedef union packed {
		bcd_t [`DIGITS-1:0] by_scan;
		digits_named_t by_name;
	} digits_u;

endpackage

`default_nettype wire

// ==== hw/hms_field.sv ====
// one wrapping time field with count and step strobes
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module hms_field #(
	parameter int MAX = 59
) (
	input  wire               i_count,	// advance with carry
	input  wire               i_step,	// advance without carry
	input  wire               clk,
	input  wire               rst_n,
	output logic [`HMS_W-1:0] o_value,
	output logic              o_carry
);

	localparam logic [`HMS_W-1:0] LAST = `HMS_W'(MAX);

	logic at_last;

	assign at_last = (o_value == LAST);
	assign o_carry = i_count & at_last;	// same-cycle carry for the next field

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
		end else if (i_count || i_step) begin
			o_value <= at_last ? '0 : o_value + 1'b1;
		end
	end

	// value stays inside the field range
	a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_value <= LAST);

endmodule

`default_nettype wire

// ==== hw/mode_ctrl.sv ====
// button sync and edge detect, mode/field/alarm-enable registers, step strobes
`default_nettype none
`timescale 1ns/1ps

module mode_ctrl (
	input  wire                 i_btn_mode,
	input  wire                 i_btn_field,
	input  wire                 i_btn_step,
	input  wire                 i_btn_alarm,
	input  wire                 clk,
	input  wire                 rst_n,
	output clock_pkg::mode_e    o_mode,
	output clock_pkg::field_e   o_field,
	output logic                o_alarm_en,
	output logic [2:0]          o_time_step,	// {hour, min, sec}
	output logic [2:0]          o_alarm_step
);

	localparam int BTN_MODE  = 0;
	localparam int BTN_FIELD = 1;
	localparam int BTN_STEP  = 2;
	localparam int BTN_ALARM = 3;

	logic [3:0] btn_in;
	logic [3:0] btn_s1;
	logic [3:0] btn_s2;
	logic [3:0] btn_d;	// edge flop
	logic [3:0] btn_rise;
	logic [2:0] field_hot;

	assign btn_in = {i_btn_alarm, i_btn_step, i_btn_field, i_btn_mode};

	// ----------------------------------------------------------
	// sync and rising edge
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_s1 <= '0;
			btn_s2 <= '0;
			btn_d  <= '0;
		end else begin
			btn_s1 <= btn_in;
			btn_s2 <= btn_s1;
			btn_d  <= btn_s2;
		end
	end

	assign btn_rise = btn_s2 & ~btn_d;

	// ----------------------------------------------------------
	// mode, field, alarm enable
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_field    <= clock_pkg::FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (btn_rise[BTN_MODE]) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SET;
					clock_pkg::MODE_SET:   o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (btn_rise[BTN_FIELD]) begin
				case (o_field)
					clock_pkg::FIELD_SEC: o_field <= clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: o_field <= clock_pkg::FIELD_HOUR;
					default:              o_field <= clock_pkg::FIELD_SEC;
				endcase
			end
			if (btn_rise[BTN_ALARM])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	always_comb begin
		case (o_field)
			clock_pkg::FIELD_SEC:  field_hot = 3'b001;
			clock_pkg::FIELD_MIN:  field_hot = 3'b010;
			clock_pkg::FIELD_HOUR: field_hot = 3'b100;
			default:               field_hot = 3'b000;
		endcase
	end

	// step edge goes to one field of the set picked by mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time_step  <= '0;
			o_alarm_step <= '0;
		end else begin
			o_time_step  <= (btn_rise[BTN_STEP] && o_mode == clock_pkg::MODE_SET) ?
				field_hot : 3'b000;
			o_alarm_step <= (btn_rise[BTN_STEP] && o_mode == clock_pkg::MODE_ALARM) ?
				field_hot : 3'b000;
		end
	end

	a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({o_time_step, o_alarm_step}));

endmodule

`default_nettype wire

// ==== hw/time_keeper.sv ====
// time_keeper: seconds tick divider and the cascaded sec/min/hour fields
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module time_keeper #(
	parameter int TICK_DIV = `TICK_DIV_DEF
) (
	input  wire              clock_pkg::mode_e i_mode,
	input  wire        [2:0] i_step,	// {hour, min, sec}
	input  wire              clk,
	input  wire              rst_n,
	output clock_pkg::hms_t  o_time
);

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0]  tick_cnt;
	logic              tick;
	logic              running;
	logic              sec_count;
	logic              sec_carry;
	logic              min_carry;
	logic [`HMS_W-1:0] sec_val;
	logic [`HMS_W-1:0] min_val;
	logic [`HMS_W-1:0] hour_val;

	assign running = (i_mode != clock_pkg::MODE_SET);	// set mode freezes time

	// ----------------------------------------------------------
	// seconds tick
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (running) begin
				if (tick_cnt == CNT_LAST) begin
					tick_cnt <= '0;
					tick     <= 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
		end
	end

	assign sec_count = tick & running;	// drop a tick that lands on entry to set

	hms_field #(.MAX(`HMS_SEC_MAX)) u_sec (
		.i_count (sec_count),
		.i_step  (i_step[0]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (sec_val),
		.o_carry (sec_carry)
	);

	hms_field #(.MAX(`HMS_MIN_MAX)) u_min (
		.i_count (sec_carry),
		.i_step  (i_step[1]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (min_val),
		.o_carry (min_carry)
	);

	hms_field #(.MAX(`HMS_HOUR_MAX)) u_hour (
		.i_count (min_carry),
		.i_step  (i_step[2]),
		.clk     (clk),
		.rst_n   (rst_n),
		.o_value (hour_val),
		.o_carry ()		// day rollover unused
	);

	assign o_time = {hour_val, min_val, sec_val};

endmodule

`default_nettype wire

// ==== verif/clock_tb.sv ====
// testbench top with button stimulus, time model, reference frames, frame checker and watchdog
`include "clock_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module clock_tb;

	localparam int TICK_DIV = 400;
	localparam int SCAN_DIV = 2;
	localparam int MID      = TICK_DIV / 2;	// read point inside a second
	localparam int WATCHDOG = TICK_DIV * 200 + 4000;

	localparam logic [1:0] M_CLOCK = 2'd0;
	localparam logic [1:0] M_SET   = 2'd1;
	localparam logic [1:0] M_ALARM = 2'd2;
	localparam logic [1:0] B_MODE  = 2'd0;
	localparam logic [1:0] B_FIELD = 2'd1;
	localparam logic [1:0] B_STEP  = 2'd2;
	localparam logic [1:0] B_ALARM = 2'd3;

	// segment codes a..g indexed by digit value with a in the msb
	localparam logic [6:0] SEG_TABLE [10] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73
	};

	typedef logic [5:0][6:0] frame_t;	// index 0 = sec ones

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;	// {alarm, step, field, mode}
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	// time model of the DUT
	int         phase;
	logic [1:0] mode_m;
	logic [1:0] field_m;
	int         t_h, t_m, t_s;
	int         a_h, a_m, a_s;
	logic       en_m;
	logic       hit_m;
	int         seed = 32'hdd25;

	frame_t     got_seg;
	frame_t     exp_seg;
	logic [5:0] got_dp;
	logic [5:0] exp_dp;
	event       frame_done;
	event       compare_done;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clock_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	clock_top #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) clock_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[0]),
		.i_btn_field (btn[1]),
		.i_btn_step  (btn[2]),
		.i_btn_alarm (btn[3]),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	// ----------------------------------------------------------
	// reference and helpers
	// ----------------------------------------------------------
	function automatic frame_t expected_frame(input int h, input int m, input int s);
		frame_t f;
		f[0] = SEG_TABLE[4'(s % 10)];
		f[1] = SEG_TABLE[4'(s / 10)];
		f[2] = SEG_TABLE[4'(m % 10)];
		f[3] = SEG_TABLE[4'(m / 10)];
		f[4] = SEG_TABLE[4'(h % 10)];
		f[5] = SEG_TABLE[4'(h / 10)];
		return f;
	endfunction

	function automatic int wrap_inc(input int v, input int max);
		return (v == max) ? 0 : v + 1;
	endfunction

	function automatic int steps_to(input int from, input int to, input int max);
		return (to - from + max + 1) % (max + 1);
	endfunction

	function automatic int rand_steps();
		return int'($unsigned($random(seed)) % 31);
	endfunction

	function automatic logic [2:0] lit_digit(input logic [5:0] enb);
		case (enb)
			6'b111110: return 3'd0;
			6'b111101: return 3'd1;
			6'b111011: return 3'd2;
			6'b110111: return 3'd3;
			6'b101111: return 3'd4;
			6'b011111: return 3'd5;
			default:   return 3'd7;	// no single digit lit
		endcase
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		fail_now($sformatf("FAILED at %0d ns: %s = %0h, expected %0h", $time, name, got, exp));
	endtask

	// ----------------------------------------------------------
	// cycle stepping with the model alongside
	// ----------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		if (mode_m != M_SET) begin	// divider frozen in set mode
			phase = phase + 1;
			if (phase == TICK_DIV) begin
				phase = 0;
				t_s = wrap_inc(t_s, `HMS_SEC_MAX);
				if (t_s == 0) begin
					t_m = wrap_inc(t_m, `HMS_MIN_MAX);
					if (t_m == 0)
						t_h = wrap_inc(t_h, `HMS_HOUR_MAX);
				end
			end
		end
		if (!en_m)
			hit_m = 1'b0;
		else if (t_h == a_h && t_m == a_m && t_s == a_s)
			hit_m = 1'b1;	// sticky until enable drops
		#2;
	endtask

	task automatic apply_press(input logic [1:0] b);
		case (b)
			B_MODE:  mode_m = (mode_m == M_ALARM) ? M_CLOCK : mode_m + 2'd1;
			B_FIELD: field_m = (field_m == 2'd2) ? 2'd0 : field_m + 2'd1;
			B_ALARM: en_m = ~en_m;
			default: begin
				if (mode_m == M_SET) begin
					case (field_m)
						2'd0:    t_s = wrap_inc(t_s, `HMS_SEC_MAX);
						2'd1:    t_m = wrap_inc(t_m, `HMS_MIN_MAX);
						default: t_h = wrap_inc(t_h, `HMS_HOUR_MAX);
					endcase
				end else if (mode_m == M_ALARM) begin
					case (field_m)
						2'd0:    a_s = wrap_inc(a_s, `HMS_SEC_MAX);
						2'd1:    a_m = wrap_inc(a_m, `HMS_MIN_MAX);
						default: a_h = wrap_inc(a_h, `HMS_HOUR_MAX);
					endcase
				end
			end
		endcase
	endtask

	// high 4 cycles then low 6 with the DUT reacting on the third edge
	task automatic press(input logic [1:0] b);
		btn[b] = 1'b1;
		repeat (3) next_cycle();
		apply_press(b);
		next_cycle();
		btn[b] = 1'b0;
		repeat (6) next_cycle();
	endtask

	task automatic press_n(input logic [1:0] b, input int n);
		repeat (n) press(b);
	endtask

	task automatic wait_mid();
		while (phase != MID)
			next_cycle();
	endtask

	task automatic check_alarm();
		assert (alarm == hit_m) else value_mismatch("o_alarm", 32'(alarm), 32'(hit_m));
	endtask

	task automatic run_seconds(input int n);
		repeat (n) begin
			next_cycle();
			wait_mid();
			check_alarm();
		end
	endtask

	// collect one scan of all six digits and hand it to the checker
	task automatic check_display();
		logic [5:0] seen;
		logic [2:0] idx;
		int         waited;
		seen   = '0;
		waited = 0;
		while (seen != 6'h3f) begin
			next_cycle();
			waited++;
			if (waited > 8 * `DIGITS * SCAN_DIV)
				fail_now("display scan stalled, not all six digits were seen");
			idx = lit_digit(seg_enb);
			if (idx != 3'd7) begin
				got_seg[idx] = seg;
				got_dp[idx]  = seg_dp;
				seen[idx]    = 1'b1;
			end
		end
		if (mode_m == M_ALARM)
			exp_seg = expected_frame(a_h, a_m, a_s);
		else
			exp_seg = expected_frame(t_h, t_m, t_s);
		exp_dp = '0;
		if (mode_m != M_CLOCK) begin
			case (field_m)
				2'd0:    exp_dp[0] = 1'b1;	// sec ones
				2'd1:    exp_dp[2] = 1'b1;	// min ones
				default: exp_dp[4] = 1'b1;	// hour ones
			endcase
		end
		-> frame_done;
		@(compare_done);
	endtask

	// enter set mode, step each field to the target and return through alarm mode
	task automatic set_clock_to(input int h, input int m, input int s);
		press(B_MODE);
		press_n(B_STEP, steps_to(t_s, s, `HMS_SEC_MAX));
		press(B_FIELD);
		press_n(B_STEP, steps_to(t_m, m, `HMS_MIN_MAX));
		press(B_FIELD);
		press_n(B_STEP, steps_to(t_h, h, `HMS_HOUR_MAX));
		press(B_FIELD);
		press(B_MODE);
		press(B_MODE);
	endtask

	// ----------------------------------------------------------
	// frame checker
	// ----------------------------------------------------------
	always @(frame_done) begin
		logic [2:0] d;
		for (d = 3'd0; d < 3'd6; d = d + 3'd1) begin
			assert (got_seg[d] == exp_seg[d])
			else value_mismatch($sformatf("o_seg digit %0d", d), 32'(got_seg[d]),
				32'(exp_seg[d]));
			assert (got_dp[d] == exp_dp[d])
			else value_mismatch($sformatf("o_seg_dp digit %0d", d), 32'(got_dp[d]),
				32'(exp_dp[d]));
		end
		-> compare_done;
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		btn     = '0;
		phase   = 0;
		mode_m  = M_CLOCK;
		field_m = 2'd0;
		t_h     = 0;
		t_m     = 0;
		t_s     = 0;
		a_h     = 0;
		a_m     = 0;
		a_s     = 0;
		en_m    = 1'b0;
		hit_m   = 1'b0;
		wait (rst_n);

		wait_mid();	// expect 00:00:00 with no dp and no alarm
		check_display();
		check_alarm();

		// counting up through the minute carry
		repeat (3) begin
			run_seconds(1);
			check_display();
		end
		run_seconds(56);
		check_display();
		repeat (2) begin
			run_seconds(1);
			check_display();
		end

		// set mode steps each field without carry
		press(B_MODE);
		press_n(B_STEP, rand_steps());
		check_display();
		press(B_FIELD);
		press_n(B_STEP, rand_steps());
		check_display();
		press(B_FIELD);
		press_n(B_STEP, rand_steps());
		check_display();
		press(B_FIELD);
		repeat (3 * TICK_DIV) next_cycle();	// still frozen
		check_display();

		// alarm mode with the clock running behind it
		press(B_MODE);
		check_display();
		press_n(B_STEP, 5 + rand_steps() % 26);	// leaves room to set the clock below it
		press(B_FIELD);
		press_n(B_STEP, rand_steps());
		press(B_FIELD);
		press_n(B_STEP, rand_steps());
		press(B_FIELD);
		wait_mid();
		check_display();
		press(B_MODE);
		run_seconds(1);
		check_display();

		// run through the match with alarm enabled
		set_clock_to(a_h, a_m, a_s - 4);
		press(B_ALARM);
		run_seconds(3);
		check_display();
		run_seconds(3);
		assert (alarm == 1'b1) else value_mismatch("o_alarm", 32'(alarm), 32'd1);
		press(B_ALARM);
		check_alarm();

		// pass the match again with enable off
		set_clock_to(a_h, a_m, a_s - 2);
		run_seconds(4);
		check_display();

		$display("STATUS: PASS");
		$finish;
	end

	// watchdog sized for about 200 simulated seconds
	initial begin
		repeat (WATCHDOG) @(posedge clk);
		fail_now($sformatf("timeout: run did not finish within %0d clock cycles", WATCHDOG));
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// testbench clock and power-on reset generator
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 20,	// ns
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// release just after an edge, away from the sampling point
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/clock_pkg.sv
hw/display_pkg.sv
hw/hms_field.sv
hw/mode_ctrl.sv
hw/time_keeper.sv
hw/alarm_keeper.sv
hw/clock_face.sv
hw/clock_top.sv
verif/tb_clock_gen.sv
verif/clock_tb.sv
